/* sources.f */
+incdir+hw
hw/trs_io_pkg.sv
hw/cmd_if.sv
hw/esp_spi_port.sv
hw/cmd_framer.sv
hw/host_regs.sv
hw/breakpoint_unit.sv
hw/trs_io_top.sv
verification/trs_io_checker.sv
verification/trs_io_asserts.sv
verification/trs_io_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the trs_io testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module trs_io_tb \
  -f sources.f \
  -o sim_trs_io

./obj_dir/sim_trs_io | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi
echo "simulation clean"

/* verification/trs_io_tb.sv */
`timescale 1ns/100ps
`include "trs_io_settings.svh"

module trs_io_tb;
  import trs_io_pkg::*;

  localparam int MAX_ROWS = 48;
  localparam int CLK_NS   = 4;

  logic       clk;
  logic       rst_n;
  logic       sck;
  logic       cs_n;
  logic       mosi;
  addr_t      bus_addr;
  logic       bus_rd;
  logic       miso;
  byte_t      kbd_data;
  rgb_t       screen_rgb;
  logic       bp_hit;
  logic [2:0] bp_idx;

  // stimulus table, one column per array
  string      t_name     [0:MAX_ROWS-1];
  logic       t_probe    [0:MAX_ROWS-1];  // bus probe, else spi command
  int         t_nbytes   [0:MAX_ROWS-1];
  byte_t      t_bytes    [0:MAX_ROWS-1][0:3];
  logic       t_resp     [0:MAX_ROWS-1];  // clock one answer byte out after
  byte_t      t_exp_resp [0:MAX_ROWS-1];
  logic       t_hold     [0:MAX_ROWS-1];  // cs_n stays low into next row
  addr_t      t_addr     [0:MAX_ROWS-1];
  byte_t      t_exp_kbd  [0:MAX_ROWS-1];
  rgb_t       t_exp_rgb  [0:MAX_ROWS-1];
  logic       t_exp_hit  [0:MAX_ROWS-1];
  logic [2:0] t_exp_idx  [0:MAX_ROWS-1];
  int         n_rows;
  logic       table_ready;

  // expected board state, stepped while rows are added
  byte_t      m_kbd [0:`TRS_KBD_ROWS-1];
  rgb_t       m_rgb;
  addr_t      m_bp  [0:`TRS_NUM_BREAKPOINTS-1];
  logic [`TRS_NUM_BREAKPOINTS-1:0] m_active;
  logic       m_en;
  logic [2:0] m_idx;   // last reported slot

  int         seed;
  logic       in_frame;
  longint     wd_ns;

  trs_io_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .bus_addr   (bus_addr),
    .bus_rd     (bus_rd),
    .miso       (miso),
    .kbd_data   (kbd_data),
    .screen_rgb (screen_rgb),
    .bp_hit     (bp_hit),
    .bp_idx     (bp_idx)
  );

  trs_io_checker chk (
    .clk        (clk),
    .kbd_data   (kbd_data),
    .screen_rgb (screen_rgb),
    .bp_hit     (bp_hit),
    .bp_idx     (bp_idx)
  );

  always #2 clk = ~clk;  // 4 ns period

  function automatic byte_t next_rand();
    return byte_t'($random(seed));
  endfunction

  // rows of the 0x38xx window picked by low address bits, ored
  function automatic byte_t expect_kbd(input addr_t a);
    byte_t v;
    v = 8'h00;
    if (a[15:8] == 8'h38)
      for (int r = 0; r < 8; r++)
        if (a[r])
          v = v | m_kbd[r];
    return v;
  endfunction

  task automatic queue_command(input string name, input int n, input byte_t b0, input byte_t b1,
                               input byte_t b2, input byte_t b3, input logic resp,
                               input byte_t exp_resp, input logic hold);
    t_name[n_rows]     = name;
    t_probe[n_rows]    = 1'b0;
    t_nbytes[n_rows]   = n;
    t_bytes[n_rows][0] = b0;
    t_bytes[n_rows][1] = b1;
    t_bytes[n_rows][2] = b2;
    t_bytes[n_rows][3] = b3;
    t_resp[n_rows]     = resp;
    t_exp_resp[n_rows] = exp_resp;
    t_hold[n_rows]     = hold;
    n_rows++;
  endtask

  // bus read probe, expectations taken from the state at this point of the table
  task automatic add_probe(input string name, input addr_t a);
    logic hit;
    hit = 1'b0;
    if (m_en)
      for (int s = 0; s < 8; s++)
        if (!hit && m_active[s] && m_bp[s] == a) begin
          hit   = 1'b1;  // first match is the lowest slot
          m_idx = 3'(s);
        end
    t_name[n_rows]    = name;
    t_probe[n_rows]   = 1'b1;
    t_addr[n_rows]    = a;
    t_exp_kbd[n_rows] = expect_kbd(a);
    t_exp_rgb[n_rows] = m_rgb;
    t_exp_hit[n_rows] = hit;
    t_exp_idx[n_rows] = m_idx;
    n_rows++;
  endtask

  task automatic keyb_row(input string name, input int row);
    byte_t v;
    v = next_rand();
    m_kbd[row % 8] = v;  // row number wraps
    queue_command(name, 3, send_keyb, byte_t'(row), v, 8'h00, 1'b0, 8'h00, 1'b0);
  endtask

  task automatic screen_color(input string name);
    byte_t r;
    byte_t g;
    byte_t b;
    r = next_rand();
    g = next_rand();
    b = next_rand();
    m_rgb = {r, g, b};
    queue_command(name, 4, set_screen_color, r, g, b, 1'b0, 8'h00, 1'b0);
  endtask

  task automatic set_bp(input string name, input int slot, input addr_t a);
    m_bp[slot]     = a;
    m_active[slot] = 1'b1;
    queue_command(name, 4, set_breakpoint, byte_t'(slot), a[7:0], a[15:8], 1'b0, 8'h00, 1'b0);
  endtask

  task automatic clear_bp(input string name, input int slot);
    m_active[slot] = 1'b0;
    queue_command(name, 2, clear_breakpoint, byte_t'(slot), 8'h00, 8'h00, 1'b0, 8'h00, 1'b0);
  endtask

  task automatic switch_bp(input string name, input logic en);
    m_en = en;
    queue_command(name, 1, en ? 8'd11 : 8'd12, 8'h00, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0);
  endtask

  task automatic build_table();
    byte_t fv;
    for (int r = 0; r < 8; r++)
      m_kbd[r] = 8'h00;
    m_rgb    = 24'hffffff;  // white out of reset
    m_active = '0;
    m_en     = 1'b0;
    m_idx    = 3'd0;
    n_rows   = 0;
    add_probe("reset_state", 16'h0000);
    queue_command("cookie", 1, get_cookie, 8'h00, 8'h00, 8'h00, 1'b1, 8'haf, 1'b0);
    queue_command("version", 1, get_version, 8'h00, 8'h00, 8'h00, 1'b1, 8'h03, 1'b0);
    keyb_row("keyb_row0", 0);
    keyb_row("keyb_row2", 2);
    keyb_row("keyb_row7", 7);
    add_probe("kbd_3801", 16'h3801);
    add_probe("kbd_3880", 16'h3880);
    add_probe("kbd_3805", 16'h3805);  // rows 0 and 2 ored
    add_probe("kbd_38ff", 16'h38ff);
    add_probe("kbd_outside_3901", 16'h3901);
    add_probe("kbd_outside_0001", 16'h0001);
    keyb_row("keyb_row10_wraps", 10);
    add_probe("kbd_3804", 16'h3804);
    screen_color("screen_color");
    add_probe("color_probe", 16'h1000);
    set_bp("set_bp2", 2, 16'h1234);
    set_bp("set_bp5", 5, 16'h4abc);
    switch_bp("enable", 1'b1);
    add_probe("hit_slot5", 16'h4abc);
    add_probe("no_match", 16'h2222);  // idx held at 5
    add_probe("hit_slot2", 16'h1234);
    set_bp("share_addr", 2, 16'h4abc);
    add_probe("shared_lowest", 16'h4abc);
    clear_bp("clear_bp2", 2);
    add_probe("after_clear", 16'h4abc);
    switch_bp("disable", 1'b0);
    add_probe("disabled", 16'h4abc);
    switch_bp("reenable", 1'b1);
    add_probe("reenabled", 16'h4abc);
    // three commands, one cs_n frame, cookie answer in between
    fv       = next_rand();
    m_kbd[3] = fv;
    queue_command("frame_keyb_cookie", 4, send_keyb, 8'd3, fv, get_cookie, 1'b1, 8'haf, 1'b1);
    screen_color("frame_color");
    add_probe("frame_row3", 16'h3808);
    add_probe("frame_rgb", 16'h0100);
    queue_command("unknown_op", 2, 8'h55, 8'haa, 8'h00, 8'h00, 1'b0, 8'h00, 1'b0);
    add_probe("unknown_kbd", 16'h38ff);
    add_probe("unknown_bp", 16'h4abc);
  endtask

  // mode 0, msb first, sck half period of 8 clk
  task automatic send_spi_byte(input byte_t tx, output byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (8) @(posedge clk);
      #1;
      rx[i] = miso;  // taken as sck rises
      sck   = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      sck = 1'b0;
    end
  endtask

  task automatic run_command(input int r);
    byte_t got;
    if (!in_frame) begin
      cs_n = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      in_frame = 1'b1;
    end
    for (int k = 0; k < t_nbytes[r]; k++)
      send_spi_byte(t_bytes[r][k], got);
    if (t_resp[r]) begin
      send_spi_byte(8'h00, got);  // filler clocks the answer out
      chk.check_resp(t_name[r], t_exp_resp[r], got);
    end
    if (!t_hold[r]) begin
      repeat (4) @(posedge clk);
      #1;
      cs_n     = 1'b1;
      in_frame = 1'b0;
    end
    repeat (4) @(posedge clk);  // settle before probing
    #1;
  endtask

  task automatic run_probe(input int r);
    bus_addr = t_addr[r];
    bus_rd   = 1'b1;  // rising edge of a read
    chk.check_probe(t_name[r], t_exp_kbd[r], t_exp_rgb[r], t_exp_hit[r], t_exp_idx[r]);
    @(posedge clk);
    #1;
    bus_rd = 1'b0;
    repeat (2) @(posedge clk);
    #1;
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    sck         = 1'b0;
    cs_n        = 1'b1;
    mosi        = 1'b0;
    bus_addr    = '0;
    bus_rd      = 1'b0;
    seed        = 94;
    in_frame    = 1'b0;
    table_ready = 1'b0;
    build_table();
    wd_ns       = longint'(n_rows) * 4 * 16 * 8 * CLK_NS + 2000;
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      if (t_probe[r])
        run_probe(r);
      else
        run_command(r);
    end
    $display("summary: %0d mismatches, %0d other failures, %0d assertion failures",
             chk.mismatch_count, chk.failure_count, dut.sva.fail_count);
    if (chk.mismatch_count == 0 && chk.failure_count == 0 && dut.sva.fail_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  // watchdog, bound by the table length
  initial begin
    wait (table_ready === 1'b1);
    #(wd_ns);
    $display("timeout: stimulus table not finished after %0d ns", wd_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verification/trs_io_asserts.sv */
`timescale 1ns/100ps

module trs_io_asserts (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     exec,
  input logic                     byte_valid,
  input logic                     resp_pending,
  input logic                     resp_load,
  input logic                     bp_hit,
  input logic                     miso,
  input trs_io_pkg::frame_state_e frame_state
);
  import trs_io_pkg::*;

  int unsigned fail_count = 0;

  exec_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) exec |=> !exec)
    else begin
      $error("exec held high two cycles");
      fail_count++;
    end

  hit_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) bp_hit |=> !bp_hit)
    else begin
      $error("bp_hit held high two cycles");
      fail_count++;
    end

  // received bytes are swallowed while an answer shifts out
  no_rx_during_resp: assert property (@(posedge clk) disable iff (!rst_n)
                                      resp_pending |-> !byte_valid)
    else begin
      $error("byte_valid pulsed with a response pending");
      fail_count++;
    end

  quiet_after_reset: assert property (@(posedge clk)
                                      $rose(rst_n) |-> !(exec | byte_valid | resp_load
                                                         | bp_hit | miso)
                                                       && frame_state == idle)
    else begin
      $error("control outputs not low right after reset");
      fail_count++;
    end

endmodule

bind trs_io_top trs_io_asserts sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .exec         (cmd_bus.exec),
  .byte_valid   (byte_valid),
  .resp_pending (spi_port.resp_pending),
  .resp_load    (resp_load),
  .bp_hit       (bp_hit),
  .miso         (miso),
  .frame_state  (framer.state)
);

/* verification/trs_io_checker.sv */
`timescale 1ns/100ps

module trs_io_checker (
  input logic              clk,
  input trs_io_pkg::byte_t kbd_data,
  input trs_io_pkg::rgb_t  screen_rgb,
  input logic              bp_hit,
  input logic [2:0]        bp_idx
);
  import trs_io_pkg::*;

  localparam int HIT_WINDOW = 4;  // clk cycles for bp_hit to show

  int mismatch_count = 0;
  int failure_count  = 0;

  // answer byte as the spi master saw it
  task automatic check_resp(input string name, input byte_t exp, input byte_t act);
    if (act !== exp) begin
      mismatch_count++;
      $display("MISMATCH %s response expected 0x%02h actual 0x%02h", name, exp, act);
    end
  endtask

  task automatic check_probe(input string name, input byte_t exp_kbd, input rgb_t exp_rgb,
                             input logic exp_hit, input logic [2:0] exp_idx);
    logic       seen;
    logic [2:0] idx_seen;
    seen     = 1'b0;
    idx_seen = 3'd0;
    @(negedge clk);  // bus_addr settled, kbd_data is combinational
    if (kbd_data !== exp_kbd) begin
      mismatch_count++;
      $display("MISMATCH %s kbd_data expected 0x%02h actual 0x%02h", name, exp_kbd, kbd_data);
    end
    if (screen_rgb !== exp_rgb) begin
      mismatch_count++;
      $display("MISMATCH %s screen_rgb expected 0x%06h actual 0x%06h", name, exp_rgb,
               screen_rgb);
    end
    repeat (HIT_WINDOW) begin
      @(negedge clk);
      if (bp_hit === 1'b1 && !seen) begin
        seen     = 1'b1;
        idx_seen = bp_idx;
      end
    end
    if (exp_hit && !seen) begin
      failure_count++;
      $display("%s: breakpoint hit expected but bp_hit never pulsed within %0d cycles",
               name, HIT_WINDOW);
    end else if (!exp_hit && seen) begin
      mismatch_count++;
      $display("MISMATCH %s bp_hit expected 0 actual 1", name);
    end else if (exp_hit && idx_seen !== exp_idx) begin
      mismatch_count++;
      $display("MISMATCH %s bp_idx expected %0d actual %0d", name, exp_idx, idx_seen);
    end else if (!exp_hit && bp_idx !== exp_idx) begin
      mismatch_count++;  // idx must hold from the last hit
      $display("MISMATCH %s held bp_idx expected %0d actual %0d", name, exp_idx, bp_idx);
    end
  endtask

endmodule

/* hw/trs_io_top.sv */
`timescale 1ns/100ps

module trs_io_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              mosi,
  input  trs_io_pkg::addr_t bus_addr,
  input  logic              bus_rd,
  output logic              miso,
  output trs_io_pkg::byte_t kbd_data,
  output trs_io_pkg::rgb_t  screen_rgb,
  output logic              bp_hit,
  output logic [2:0]        bp_idx
);
  import trs_io_pkg::*;

  logic  byte_valid;  // spi byte strobe
  byte_t rx_byte;
  logic  resp_load;   // response request back to spi
  byte_t resp_byte;

  cmd_if cmd_bus ();  // executed command

  esp_spi_port spi_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .sck        (sck),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .resp_load  (resp_load),
    .resp_byte  (resp_byte),
    .miso       (miso),
    .byte_valid (byte_valid),
    .rx_byte    (rx_byte)
  );

  cmd_framer framer (
    .clk        (clk),
    .rst_n      (rst_n),
    .byte_valid (byte_valid),
    .rx_byte    (rx_byte),
    .cmd        (cmd_bus.framer)
  );

  // keyboard, colour, cookie and version
  host_regs regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd_bus.consumer),
    .bus_addr   (bus_addr),
    .kbd_data   (kbd_data),
    .screen_rgb (screen_rgb),
    .resp_load  (resp_load),
    .resp_byte  (resp_byte)
  );

  breakpoint_unit bp_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd_bus.consumer),
    .bus_addr (bus_addr),
    .bus_rd   (bus_rd),
    .bp_hit   (bp_hit),
    .bp_idx   (bp_idx)
  );

endmodule

/* hw/breakpoint_unit.sv */
`timescale 1ns/100ps
`include "trs_io_settings.svh"

module breakpoint_unit (
  input  logic              clk,
  input  logic              rst_n,
  cmd_if.consumer           cmd,
  input  trs_io_pkg::addr_t bus_addr,
  input  logic              bus_rd,
  output logic              bp_hit,
  output logic [2:0]        bp_idx
);
  import trs_io_pkg::*;

  localparam int SLOTS = `TRS_NUM_BREAKPOINTS;

  addr_t            bp_addr [0:SLOTS-1];
  logic [SLOTS-1:0] bp_active;
  logic             bp_en;       // global enable
  logic             bus_rd_q;
  logic             rd_rise;
  logic [SLOTS-1:0] match;
  logic [2:0]       hit_sel;     // lowest matching slot

  // slot addresses
  always_ff @(posedge clk) begin
    if (cmd.exec && cmd.op == set_breakpoint)
      bp_addr[cmd.p0[2:0]] <= {cmd.p2, cmd.p1};  // p1 is the low byte
  end

  // slot flags and enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bp_active <= '0;
      bp_en     <= 1'b0;
    end else if (cmd.exec) begin
      case (cmd.op)
        set_breakpoint:      bp_active[cmd.p0[2:0]] <= 1'b1;
        clear_breakpoint:    bp_active[cmd.p0[2:0]] <= 1'b0;
        enable_breakpoints:  bp_en <= 1'b1;
        disable_breakpoints: bp_en <= 1'b0;
        default: ;
      endcase
    end
  end

  assign rd_rise = bus_rd & ~bus_rd_q;

  // compare every slot, then pick lowest index
  always_comb begin
    hit_sel = 3'd0;
    for (int i = 0; i < SLOTS; i++)
      match[i] = bp_active[i] && (bp_addr[i] == bus_addr);
    for (int i = SLOTS - 1; i >= 0; i--)
      if (match[i])
        hit_sel = 3'(i);  // lower slots overwrite higher ones
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bus_rd_q <= 1'b0;
      bp_hit   <= 1'b0;
      bp_idx   <= 3'd0;
    end else begin
      bus_rd_q <= bus_rd;
      bp_hit   <= rd_rise && bp_en && (|match);
      if (rd_rise && bp_en && (|match))
        bp_idx <= hit_sel;  // held until next hit
    end
  end

endmodule

/* hw/host_regs.sv */
`timescale 1ns/100ps
`include "trs_io_settings.svh"

module host_regs (
  input  logic              clk,
  input  logic              rst_n,
  cmd_if.consumer           cmd,
  input  trs_io_pkg::addr_t bus_addr,
  output trs_io_pkg::byte_t kbd_data,
  output trs_io_pkg::rgb_t  screen_rgb,
  output logic              resp_load,
  output trs_io_pkg::byte_t resp_byte
);
  import trs_io_pkg::*;

  localparam int ROW_BITS = $clog2(`TRS_KBD_ROWS);

  byte_t kbd_rows [0:`TRS_KBD_ROWS-1];  // one byte per matrix row

  // keyboard matrix and screen colour
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < `TRS_KBD_ROWS; r++)
        kbd_rows[r] <= '0;  // no keys down
      screen_rgb <= `TRS_SCREEN_RESET;
    end else if (cmd.exec) begin
      if (cmd.op == send_keyb)
        kbd_rows[cmd.p0[ROW_BITS-1:0]] <= cmd.p1;  // row wraps mod 8
      if (cmd.op == set_screen_color)
        screen_rgb <= {cmd.p0, cmd.p1, cmd.p2};      // r, g, b
    end
  end

  // z80 read of 0x38xx, each set low address bit selects a row
  always_comb begin
    kbd_data = '0;
    if (bus_addr[15:8] == `TRS_KBD_PAGE) begin
      for (int r = 0; r < `TRS_KBD_ROWS; r++)
        if (bus_addr[r])
          kbd_data = kbd_data | kbd_rows[r];  // rows wire-or like the real matrix
    end
  end

  // single byte answers
  always_ff @(posedge clk) begin
    if (!rst_n)
      resp_load <= 1'b0;
    else
      resp_load <= cmd.exec && (cmd.op == get_cookie || cmd.op == get_version);
  end

  always_ff @(posedge clk) begin
    if (cmd.exec && cmd.op == get_cookie)
      resp_byte <= `TRS_COOKIE;
    else if (cmd.exec && cmd.op == get_version)
      resp_byte <= {`TRS_VERSION_MAJOR, `TRS_VERSION_MINOR};
  end

endmodule

/* hw/cmd_framer.sv */
`timescale 1ns/100ps
`include "trs_io_settings.svh"

module cmd_framer (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              byte_valid,
  input  trs_io_pkg::byte_t rx_byte,
  cmd_if.framer             cmd
);
  import trs_io_pkg::*;

  frame_state_e state;
  esp_cmd_e     op_pend;                        // opcode waiting for its params
  byte_t        param_buf [0:`TRS_MAX_PARAMS-1];
  byte_t        params_nxt [0:`TRS_MAX_PARAMS-1];
  logic [1:0]   param_idx;                      // next slot to fill
  logic [1:0]   param_left;                     // bytes still expected
  logic [1:0]   need;                           // param count of incoming opcode
  logic         op_known;

  // parameter count per opcode
  always_comb begin
    op_known = 1'b1;
    case (esp_cmd_e'(rx_byte))
      set_breakpoint,
      set_screen_color: need = 2'd3;
      send_keyb:        need = 2'd2;
      clear_breakpoint: need = 2'd1;
      get_cookie, get_version,
      enable_breakpoints,
      disable_breakpoints: need = 2'd0;
      default: begin
        need     = 2'd0;
        op_known = 1'b0;  // ignored
      end
    endcase
  end

  // buffer with the incoming byte merged in
  always_comb begin
    params_nxt            = param_buf;
    params_nxt[param_idx] = rx_byte;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= idle;
      param_left <= 2'd0;
      cmd.exec   <= 1'b0;
    end else begin
      cmd.exec <= 1'b0;
      if (byte_valid) begin
        case (state)
          idle: begin
            if (op_known && need == 2'd0) begin
              cmd.exec <= 1'b1;  // no params, run now
            end else if (op_known) begin
              state      <= read_params;
              param_left <= need;
            end
          end
          read_params: begin
            if (param_left == 2'd1) begin
              cmd.exec <= 1'b1;
              state    <= idle;
            end else begin
              param_left <= param_left - 2'd1;
            end
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // opcode and params only move to the interface at exec
  always_ff @(posedge clk) begin
    if (byte_valid && state == idle) begin
      op_pend   <= esp_cmd_e'(rx_byte);
      param_idx <= 2'd0;
      if (op_known && need == 2'd0)
        cmd.op <= esp_cmd_e'(rx_byte);
    end else if (byte_valid) begin
      param_buf <= params_nxt;
      param_idx <= param_idx + 2'd1;
      if (param_left == 2'd1) begin
        cmd.op <= op_pend;
        cmd.p0 <= params_nxt[0];
        cmd.p1 <= params_nxt[1];
        cmd.p2 <= params_nxt[2];
      end
    end
  end

endmodule

/* hw/esp_spi_port.sv */
`timescale 1ns/100ps

module esp_spi_port (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              sck,
  input  logic              cs_n,
  input  logic              mosi,
  input  logic              resp_load,   // arm a response
  input  trs_io_pkg::byte_t resp_byte,
  output logic              miso,
  output logic              byte_valid,
  output trs_io_pkg::byte_t rx_byte
);
  import trs_io_pkg::*;

  logic [2:0] sck_sync;   // [0] meta, [1] sync, [2] previous
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic       mosi_bit;
  logic [2:0] bit_cnt;    // bits of current byte
  byte_t      rx_shift;
  byte_t      tx_shift;
  logic [3:0] tx_cnt;     // 9 = armed, 8..1 = shifting
  logic       resp_pending;

  // synchronizers into the clk domain
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sck_sync  <= 3'b000;
      cs_sync   <= 2'b11;  // deselected
      mosi_sync <= 2'b00;
    end else begin
      sck_sync  <= {sck_sync[1:0], sck};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
    end
  end

  assign sck_rise  = sck_sync[1] & ~sck_sync[2];
  assign sck_fall  = ~sck_sync[1] & sck_sync[2];
  assign cs_active = ~cs_sync[1];
  assign mosi_bit  = mosi_sync[1];

  assign resp_pending = (tx_cnt != 4'd0);

  // receive side, mode 0 so sample on rising sck
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= cs_active && sck_rise && (bit_cnt == 3'd7) && !resp_pending;
      if (!cs_active)
        bit_cnt <= 3'd0;  // frame boundary realigns bytes
      else if (sck_rise)
        bit_cnt <= bit_cnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (cs_active && sck_rise)
      rx_shift <= {rx_shift[6:0], mosi_bit};  // msb first
  end

  assign rx_byte = rx_shift;  // complete when byte_valid is high

  // transmit side, master samples on rising so change on falling
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_cnt   <= 4'd0;
      tx_shift <= '0;
    end else if (resp_load) begin
      tx_cnt <= 4'd9;
    end else if (!cs_active) begin
      tx_cnt <= 4'd0;  // dropped frame abandons the response
    end else if (sck_fall && resp_pending) begin
      if (tx_cnt == 4'd9)
        tx_shift <= resp_byte;  // bit 7 out ahead of first rising edge
      else
        tx_shift <= {tx_shift[6:0], 1'b0};
      tx_cnt <= tx_cnt - 4'd1;
    end
  end

  assign miso = cs_active & tx_shift[7];  // zeros shifted in keep it low when idle

endmodule

/* hw/cmd_if.sv */
`timescale 1ns/100ps

// one executed host command, framer to consumers
interface cmd_if;
  import trs_io_pkg::*;

  logic     exec;  // single-cycle strobe
  esp_cmd_e op;    // held until the next exec
  byte_t    p0;
  byte_t    p1;
  byte_t    p2;

  modport framer   (output exec, op, p0, p1, p2);
  modport consumer (input  exec, op, p0, p1, p2);

endinterface

/* hw/trs_io_pkg.sv */
package trs_io_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] addr_t;  // z80 address
  typedef logic [23:0] rgb_t;   // red in [23:16], blue in [7:0]

  // host command opcodes, values as the ESP firmware sends them
  typedef enum logic [7:0] {
    get_cookie          = 8'd0,
    set_breakpoint      = 8'd6,
    clear_breakpoint    = 8'd7,
    enable_breakpoints  = 8'd11,
    disable_breakpoints = 8'd12,
    get_version         = 8'd15,
    set_screen_color    = 8'd17,
    send_keyb           = 8'd19
  } esp_cmd_e;

  // framer states
  typedef enum logic {
    idle        = 1'b0,  // waiting for an opcode
    read_params = 1'b1   // collecting parameter bytes
  } frame_state_e;

endpackage

/* hw/trs_io_settings.svh */
`ifndef TRS_IO_SETTINGS_SVH
`define TRS_IO_SETTINGS_SVH

// answer to get_cookie, lets the host find the board
`define TRS_COOKIE 8'haf

// version byte is {major, minor}
`define TRS_VERSION_MAJOR 3'd0
`define TRS_VERSION_MINOR 5'd3

// breakpoint slots
`define TRS_NUM_BREAKPOINTS 8

// keyboard matrix, one row per low address bit
`define TRS_KBD_ROWS 8
`define TRS_KBD_PAGE 8'h38  // upper address byte of the 0x38xx window

// longest parameter list of any command
`define TRS_MAX_PARAMS 3

`define TRS_SCREEN_RESET 24'hffffff  // white

`endif
